//--- rtl/chart_fetch.sv
`timescale 1ns/1ps

module chart_fetch (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    chart_valid,
    input  rhythm_pkg::chart_note_t chart_note,
    output logic                    chart_ready,
    input  logic                    target_take,
    output logic                    target_valid,
    output rhythm_pkg::chart_note_t target,
    output logic                    finished
);
    logic armed;        // stream opens the cycle after reset
    logic last_take;
    logic load;

    assign last_take   = target_take & target.last;
    // Nothing past the last note is accepted
    assign chart_ready = armed & ~finished & ~last_take & (~target_valid | target_take);
    assign load        = chart_valid & chart_ready;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            armed        <= 1'b0;
            target_valid <= 1'b0;
            finished     <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (load)
                target_valid <= 1'b1;
            else if (target_take)
                target_valid <= 1'b0;
            if (last_take)
                finished <= 1'b1;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (load)
            target <= chart_note;
    end

    chart_note_legal: assert property (@(posedge prog_clk) disable iff (rst)
        chart_valid |-> ($onehot0(chart_note.note.key) &&
                         !(chart_note.note.oct_down && chart_note.note.oct_up)));

    take_needs_target: assert property (@(posedge prog_clk) disable iff (rst)
        target_take |-> target_valid);

endmodule

//--- rtl/hit_judge.sv
`timescale 1ns/1ps

module hit_judge (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    auto_play,
    input  rhythm_pkg::note_t       keys,
    input  logic                    step_due,
    input  logic                    target_valid,
    input  rhythm_pkg::chart_note_t target,
    output logic                    target_take,
    output logic                    step_taken,
    input  logic                    res_ready,
    output logic                    res_valid,
    output rhythm_pkg::result_t     res
);
    localparam int SW = rhythm_pkg::SCORE_W;

    rhythm_pkg::note_t  hist_1;     // keys at the previous step
    rhythm_pkg::note_t  hist_2;     // keys two steps back
    rhythm_pkg::note_t  played;
    rhythm_pkg::grade_t grade;
    logic [SW-1:0]      pts;
    logic [SW-1:0]      score;
    logic               step;

    // Step needs a due period, a target and a free result slot
    assign step        = step_due & target_valid & (~res_valid | res_ready);
    assign step_taken  = step;
    assign target_take = step;

    // Grade against the current keys first, then the history
    always_comb begin
        played = keys;
        grade  = rhythm_pkg::GRADE_MISS;
        pts    = '0;
        if (auto_play) begin
            played = target.note;
            grade  = rhythm_pkg::GRADE_AUTO;
            pts    = SW'(rhythm_pkg::PTS_AUTO);
        end else if (target.note == keys) begin
            grade = rhythm_pkg::GRADE_PERFECT;
            pts   = SW'(rhythm_pkg::PTS_PERFECT);
        end else if (target.note == hist_1) begin
            grade = rhythm_pkg::GRADE_GREAT;
            pts   = SW'(rhythm_pkg::PTS_GREAT);
        end else if (target.note == hist_2) begin
            grade = rhythm_pkg::GRADE_GOOD;
            pts   = SW'(rhythm_pkg::PTS_GOOD);
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            hist_1    <= '0;
            hist_2    <= '0;
            score     <= '0;
            res_valid <= 1'b0;
        end else if (step) begin
            hist_1    <= keys;
            hist_2    <= hist_1;
            score     <= score + pts;
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (step) begin
            res.note  <= played;
            res.grade <= grade;
            res.score <= score + pts;
        end
    end

endmodule

//--- rtl/play_timer.sv
`timescale 1ns/1ps

module play_timer #(
    parameter int unsigned COUNT_TICKS = 2,
    parameter int unsigned STEP_TICKS  = 2
) (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       step_taken,
    input  logic       finished,
    output logic [1:0] countdown,
    output logic       playing,
    output logic       step_due
);
    localparam int CW = $clog2(COUNT_TICKS);
    localparam int SW = $clog2(STEP_TICKS);

    logic [CW-1:0] cd_cnt;
    logic [SW-1:0] step_cnt;
    logic          started;

    assign playing = started & ~finished;

    // Countdown 3, 2, 1, 0, then play starts
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cd_cnt    <= '0;
            countdown <= 2'd3;
            started   <= 1'b0;
        end else if (!started) begin
            if (cd_cnt == CW'(COUNT_TICKS - 1)) begin
                cd_cnt <= '0;
                if (countdown == 2'd0)
                    started <= 1'b1;
                else
                    countdown <= countdown - 2'd1;
            end else begin
                cd_cnt <= cd_cnt + 1'b1;
            end
        end
    end

    // Step period, restarted at 1 so steps are STEP_TICKS apart
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            step_due <= 1'b0;
        end else if (step_taken) begin
            step_cnt <= SW'(1);
            step_due <= 1'b0;
        end else if (finished) begin
            step_due <= 1'b0;
        end else if (playing && !step_due) begin
            if (step_cnt == SW'(STEP_TICKS - 1))
                step_due <= 1'b1;
            else
                step_cnt <= step_cnt + 1'b1;
        end
    end

    step_only_when_due: assert property (@(posedge prog_clk) disable iff (rst)
        step_taken |-> step_due);

endmodule

//--- rtl/rhythm_pkg.sv
package rhythm_pkg;

    // One note of a chart or of the player's keys
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] key;      // one-hot, bit 0 is C and bit 6 is B, zero is a rest
    } note_t;

    // Note as it arrives on the chart stream
    typedef struct packed {
        logic  last;
        note_t note;
    } chart_note_t;

    typedef enum logic [2:0] {
        GRADE_MISS,
        GRADE_GOOD,
        GRADE_GREAT,
        GRADE_PERFECT,
        GRADE_AUTO
    } grade_t;

    // Running score width
    parameter int SCORE_W = 14;

    // One result per note step
    typedef struct packed {
        note_t              note;
        grade_t             grade;
        logic [SCORE_W-1:0] score;
    } result_t;

    // Points per grade
    parameter int PTS_PERFECT = 5;
    parameter int PTS_GREAT   = 3;
    parameter int PTS_GOOD    = 1;
    parameter int PTS_AUTO    = 4;

    // Bit 0 octave lamp, bits 7..1 key lamps with C on bit 7
    typedef logic [7:0] led_t;

endpackage

//--- rtl/rhythm_play_top.sv
`timescale 1ns/1ps

module rhythm_play_top #(
    parameter int unsigned COUNT_TICKS = 100_000_000,  // one second at 100 MHz
    parameter int unsigned STEP_TICKS  = 25_000_000
) (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    auto_play,
    input  rhythm_pkg::note_t       keys,
    input  logic                    chart_valid,
    input  rhythm_pkg::chart_note_t chart_note,
    output logic                    chart_ready,
    output logic                    result_valid,
    output rhythm_pkg::result_t     result,
    input  logic                    result_ready,
    output rhythm_pkg::led_t        led,
    output logic [1:0]              countdown,
    output logic                    playing,
    output logic                    finished
);
    // Step timing
    logic step_due;
    logic step_taken;

    // Target link
    logic                    target_valid;
    logic                    target_take;
    rhythm_pkg::chart_note_t target;

    // Result link
    logic                res_valid;
    logic                res_ready;
    rhythm_pkg::result_t res;

    play_timer #(
        .COUNT_TICKS (COUNT_TICKS),
        .STEP_TICKS  (STEP_TICKS)
    ) play_timer_inst (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .step_taken (step_taken),
        .finished   (finished),
        .countdown  (countdown),
        .playing    (playing),
        .step_due   (step_due)
    );

    chart_fetch chart_fetch_inst (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .chart_valid  (chart_valid),
        .chart_note   (chart_note),
        .chart_ready  (chart_ready),
        .target_take  (target_take),
        .target_valid (target_valid),
        .target       (target),
        .finished     (finished)
    );

    hit_judge hit_judge_inst (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .auto_play    (auto_play),
        .keys         (keys),
        .step_due     (step_due),
        .target_valid (target_valid),
        .target       (target),
        .target_take  (target_take),
        .step_taken   (step_taken),
        .res_ready    (res_ready),
        .res_valid    (res_valid),
        .res          (res)
    );

    step_emitter step_emitter_inst (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .res_valid    (res_valid),
        .res          (res),
        .res_ready    (res_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready),
        .led          (led)
    );

endmodule

//--- rtl/step_emitter.sv
`timescale 1ns/1ps

module step_emitter (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                res_valid,
    input  rhythm_pkg::result_t res,
    output logic                res_ready,
    output logic                result_valid,
    output rhythm_pkg::result_t result,
    input  logic                result_ready,
    output rhythm_pkg::led_t    led
);
    rhythm_pkg::led_t led_next;
    logic             key_one_hot;
    logic             load;

    // Room when empty or draining this cycle
    assign res_ready = ~result_valid | result_ready;
    assign load      = res_valid & res_ready;

    assign key_one_hot = (res.note.key != 7'd0) &&
                         ((res.note.key & (res.note.key - 7'd1)) == 7'd0);

    // Key lamps mirrored, C on bit 7 and B on bit 1
    always_comb begin
        led_next    = '0;
        led_next[0] = res.note.oct_down | res.note.oct_up;
        if (key_one_hot) begin
            for (int i = 0; i < 7; i++)
                led_next[7 - i] = res.note.key[i];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
            led          <= '0;
        end else if (load) begin
            result_valid <= 1'b1;
            led          <= led_next;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (load)
            result <= res;
    end

    // Held result under back-pressure
    result_stable: assert property (@(posedge prog_clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rhythm_play \
    -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sources.f
rtl/rhythm_pkg.sv
rtl/play_timer.sv
rtl/chart_fetch.sv
rtl/hit_judge.sv
rtl/step_emitter.sv
rtl/rhythm_play_top.sv
tb/tb_rhythm_play.sv

//--- tb/tb_rhythm_play.sv
`timescale 1ns/1ps

module tb_rhythm_play;
    localparam int COUNT_TICKS = 6;
    localparam int STEP_TICKS  = 4;
    localparam int N_NOTES     = 16;
    localparam int TIMEOUT     = 400;

    logic                    prog_clk = 1'b0;
    logic                    rst;
    logic                    auto_play;
    rhythm_pkg::note_t       keys;
    logic                    chart_valid;
    rhythm_pkg::chart_note_t chart_note;
    logic                    chart_ready;
    logic                    result_valid;
    rhythm_pkg::result_t     result;
    logic                    result_ready;
    rhythm_pkg::led_t        led;
    logic [1:0]              countdown;
    logic                    playing;
    logic                    finished;

    rhythm_pkg::chart_note_t chart [N_NOTES];
    rhythm_pkg::note_t       key_plan [N_NOTES];
    rhythm_pkg::result_t     exp_q [$];
    int                      results_seen;
    logic                    bp_en;
    string                   test_name;

    rhythm_play_top #(
        .COUNT_TICKS (COUNT_TICKS),
        .STEP_TICKS  (STEP_TICKS)
    ) rhythm_play_top_inst (.*);

    always #4 prog_clk = ~prog_clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic value_err(input string what, input logic [31:0] exp, input logic [31:0] act);
        fail_now($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    // Legal note, rest included
    function automatic rhythm_pkg::note_t rand_note();
        rhythm_pkg::note_t n;
        int                k;
        k = $urandom_range(0, 7);
        n.key = (k == 7) ? 7'd0 : 7'(1 << k);
        k = $urandom_range(0, 2);
        n.oct_up   = (k == 1);
        n.oct_down = (k == 2);
        return n;
    endfunction

    // C lights bit 7, B lights bit 1
    function automatic rhythm_pkg::led_t led_of(input rhythm_pkg::note_t n);
        rhythm_pkg::led_t l;
        l    = '0;
        l[0] = n.oct_down | n.oct_up;
        for (int i = 0; i < 7; i++) begin
            if (n.key == 7'(1 << i))
                l[7 - i] = 1'b1;
        end
        return l;
    endfunction

    // Chart, key plan and expected results from the grading rules
    task automatic build_run(input bit auto);
        rhythm_pkg::note_t              h1;
        rhythm_pkg::note_t              h2;
        rhythm_pkg::grade_t             grade;
        logic [rhythm_pkg::SCORE_W-1:0] score;
        int                             pts;
        rhythm_pkg::result_t            exp_res;
        h1    = '0;
        h2    = '0;
        score = '0;
        for (int i = 0; i < N_NOTES; i++)
            chart[i] = '{last: (i == N_NOTES - 1), note: rand_note()};
        for (int i = 0; i < N_NOTES; i++) begin
            case ($urandom_range(0, 3))
                0: key_plan[i] = chart[i].note;
                1: key_plan[i] = chart[(i + 1) % N_NOTES].note;
                2: key_plan[i] = chart[(i + 2) % N_NOTES].note;
                default: key_plan[i] = rand_note();
            endcase
            if (auto)
                key_plan[i] = '0;
            grade = rhythm_pkg::GRADE_MISS;
            pts   = 0;
            if (auto) begin
                grade = rhythm_pkg::GRADE_AUTO;
                pts   = rhythm_pkg::PTS_AUTO;
            end else if (chart[i].note == key_plan[i]) begin
                grade = rhythm_pkg::GRADE_PERFECT;
                pts   = rhythm_pkg::PTS_PERFECT;
            end else if (chart[i].note == h1) begin
                grade = rhythm_pkg::GRADE_GREAT;
                pts   = rhythm_pkg::PTS_GREAT;
            end else if (chart[i].note == h2) begin
                grade = rhythm_pkg::GRADE_GOOD;
                pts   = rhythm_pkg::PTS_GOOD;
            end
            h2    = h1;
            h1    = key_plan[i];
            score = score + pts[rhythm_pkg::SCORE_W-1:0];
            exp_res.note  = auto ? chart[i].note : key_plan[i];
            exp_res.grade = grade;
            exp_res.score = score;
            exp_q.push_back(exp_res);
        end
    endtask

    // Each countdown value and the wait for playing take COUNT_TICKS cycles
    task automatic check_countdown();
        int n;
        for (int stage = 0; stage < 4; stage++) begin
            n = 0;
            do begin
                @(posedge prog_clk);
                #1;
                n++;
                if (n > 4 * COUNT_TICKS)
                    fail_now("countdown did not advance");
            end while (stage < 3 ? countdown != 2'(2 - stage) : !playing);
            assert (n == COUNT_TICKS) else value_err("countdown stage", COUNT_TICKS, n);
        end
    endtask

    task automatic feed_chart();
        int   n;
        logic got;
        for (int i = 0; i < N_NOTES; i++) begin
            chart_valid = 1'b1;
            chart_note  = chart[i];
            n = 0;
            do begin
                @(posedge prog_clk);
                got = chart_ready;
                #1;
                n++;
                if (n > TIMEOUT)
                    fail_now("chart note was not accepted");
            end while (!got);
        end
        chart_valid = 1'b0;
    endtask

    // Next keys only once the previous result is out
    task automatic play_keys();
        int n;
        for (int i = 0; i < N_NOTES; i++) begin
            keys = key_plan[i];
            n = 0;
            while (results_seen <= i) begin
                @(posedge prog_clk);
                #1;
                n++;
                if (n > TIMEOUT)
                    fail_now("result for a chart step never arrived");
            end
        end
    endtask

    task automatic run_chart(input bit auto, input string name);
        int n;
        test_name    = name;
        build_run(auto);
        rst          = 1'b1;
        auto_play    = auto;
        bp_en        = auto;
        keys         = key_plan[0];
        results_seen = 0;
        repeat (4) @(posedge prog_clk);
        #1;
        assert (!chart_ready && !result_valid && !playing && !finished && led == '0)
            else fail_now("outputs not idle during reset");
        assert (countdown == 2'd3) else value_err("reset countdown", 3, countdown);
        rst = 1'b0;
        // Chart is already offered during the countdown
        fork
            check_countdown();
            feed_chart();
            play_keys();
        join
        n = 0;
        while (!finished) begin
            @(posedge prog_clk);
            #1;
            n++;
            if (n > TIMEOUT)
                fail_now("finished did not rise after the last note");
        end
        repeat (4 * STEP_TICKS) @(posedge prog_clk);
        #1;
        assert (exp_q.size() == 0) else value_err("pending results", 0, exp_q.size());
    endtask

    // Random stall stretches on the result port
    always @(posedge prog_clk) begin
        #1;
        result_ready = bp_en ? ($urandom_range(0, 2) == 0) : 1'b1;
    end

    always @(posedge prog_clk) begin
        if (!rst && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                fail_now("unexpected result after the end of the chart");
            end else begin
                assert (result == exp_q[0])
                    else value_err("result", 32'(exp_q[0]), 32'(result));
                assert (led == led_of(exp_q[0].note))
                    else value_err("led", 32'(led_of(exp_q[0].note)), 32'(led));
                void'(exp_q.pop_front());
                results_seen++;
            end
        end
    end

    result_held: assert property (@(posedge prog_clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else fail_now("result changed or dropped while stalled");

    quiet_before_play: assert property (@(posedge prog_clk) disable iff (rst)
        !playing && !finished |-> !result_valid)
        else fail_now("result_valid before play started");

    closed_after_end: assert property (@(posedge prog_clk) disable iff (rst)
        finished |-> !chart_ready && !playing)
        else fail_now("chart_ready or playing high after the end of the chart");

    initial begin
        void'($urandom(32'hb74a_d4ce));
        rst          = 1'b1;
        auto_play    = 1'b1;
        keys         = '0;
        chart_valid  = 1'b0;
        chart_note   = '0;
        result_ready = 1'b1;
        bp_en        = 1'b0;
        results_seen = 0;
        test_name    = "init";
        run_chart(1'b1, "auto_play");
        run_chart(1'b0, "player");
        $display("TEST PASS");
        $finish;
    end

endmodule
